/* sim.f */
+incdir+rtl
+incdir+sim
rtl/vmem_pkg.sv
rtl/cpu_state_seq.sv
rtl/mem_op_latch.sv
rtl/vmem_map.sv
rtl/vmem_ctl.sv
rtl/vmem_top.sv
sim/tb_vmem.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench and RTL with Verilator, then run the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_vmem -f sim.f -o tb_vmem
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/tb_vmem
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit "$status"
fi

exit 0

/* sim/tb_vmem_model.svh */
`ifndef TB_VMEM_MODEL_SVH
`define TB_VMEM_MODEL_SVH

////////////////////////////////////////////////////////////
// Map mirror kept in step with every map write.
////////////////////////////////////////////////////////////

l2_blk_t    model_l1 [2**(`L1_IDX_HI-`L1_IDX_LO+1)];
map_entry_t model_l2 [2**(`L2_BLK_W+`L2_IDX_HI-`L2_IDX_LO+1)];

// Level-2 slot is the block number from level 1 joined with the middle address bits.
function automatic logic [`L2_BLK_W+`L2_IDX_HI-`L2_IDX_LO:0] l2_slot(
   input logic [`VMA_W-1:0] a);
   return {model_l1[a[`L1_IDX_HI:`L1_IDX_LO]], a[`L2_IDX_HI:`L2_IDX_LO]};
endfunction

function automatic void model_write(input logic to_l2, input logic [`VMA_W-1:0] a,
                                    input map_entry_t d);
   if (to_l2) begin
      model_l2[l2_slot(a)] = d;
   end else begin
      model_l1[a[`L1_IDX_HI:`L1_IDX_LO]] = d[`L2_BLK_W-1:0];
   end
endfunction

function automatic map_entry_t model_lookup(input logic [`VMA_W-1:0] a);
   return model_l2[l2_slot(a)];
endfunction

// Reads and ifetches need the access bit, writes need access and write.
function automatic logic model_grant(input map_entry_t ent, input mem_op_e o);
   return ent[`MAP_WDATA_W-1] && ((o != op_write) || ent[`MAP_WDATA_W-2]);
endfunction

////////////////////////////////////////////////////////////
// Compare tasks.
////////////////////////////////////////////////////////////

task automatic stop_with_error(input string why);
   $display("%s", why);
   $display("Test FAILED");
   $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      stop_with_error($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
   end
endtask

task automatic check_addr(input string name, input logic [`PPAGE_W+`PAGE_OFF_W-1:0] got,
                          input logic [`PPAGE_W+`PAGE_OFF_W-1:0] exp);
   if (got !== exp) begin
      stop_with_error($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
   end
endtask

task automatic check_state(input string name, input cpu_state_e got, input cpu_state_e exp);
   if (got !== exp) begin
      stop_with_error($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
   end
endtask

`endif

/* sim/tb_vmem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vmem_consts.svh"

module tb_vmem;

   import vmem_pkg::*;

   localparam int access_count = 150;
   localparam int wait_limit   = 40;

   logic                            clk;
   logic                            reset;
   logic                            req;
   mem_op_e                         op;
   logic [`VMA_W-1:0]               vma;
   logic                            map_wr_l1;
   logic                            map_wr_l2;
   logic [`MAP_WDATA_W-1:0]         map_wdata;
   logic                            lcinc;
   logic                            needfetch;
   logic                            memack;
   cpu_state_e                      state;
   logic                            memrq;
   logic [`PPAGE_W+`PAGE_OFF_W-1:0] phys_addr;
   logic                            wrcyc;
   logic                            vmaok;
   logic                            pfr;
   logic                            pfw;
   logic                            map_fault;
   logic                            waiting;

   logic [31:0] lfsr_q;
   int          n_granted;
   int          n_denied;

   `include "tb_vmem_model.svh"

   vmem_top uut (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .op        (op),
      .vma       (vma),
      .map_wr_l1 (map_wr_l1),
      .map_wr_l2 (map_wr_l2),
      .map_wdata (map_wdata),
      .lcinc     (lcinc),
      .needfetch (needfetch),
      .memack    (memack),
      .state     (state),
      .memrq     (memrq),
      .phys_addr (phys_addr),
      .wrcyc     (wrcyc),
      .vmaok     (vmaok),
      .pfr       (pfr),
      .pfw       (pfw),
      .map_fault (map_fault),
      .waiting   (waiting)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Random source.
   ////////////////////////////////////////////////////////////

   // Taps 32, 22, 2, 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
   endtask

   function automatic mem_op_e op_from_bits(input logic [1:0] b);
      case (b)
         2'd2:    return op_write;
         2'd3:    return op_ifetch;
         default: return op_read;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Stimulus and memory side.
   ////////////////////////////////////////////////////////////

   task automatic map_write(input logic to_l2, input logic [`VMA_W-1:0] a,
                            input map_entry_t d);
      @(posedge clk);
      map_wr_l1 <= ~to_l2;
      map_wr_l2 <= to_l2;
      vma       <= a;
      map_wdata <= d;
      @(posedge clk);
      map_wr_l1 <= 1'b0;
      map_wr_l2 <= 1'b0;
      model_write(to_l2, a, d);
   endtask

   // Returns at a negedge in prefetch with no stall, so decode follows.
   task automatic wait_issue_slot();
      int n;
      n = 0;
      @(negedge clk);
      while (!(state == st_prefetch && !waiting)) begin
         if (n == wait_limit) begin
            stop_with_error("Timed out waiting for the processor to finish its cycle");
         end else begin
            n++;
            @(negedge clk);
         end
      end
   endtask

   task automatic check_stalled(input logic wr);
      check_bit("memrq", memrq, 1'b1);
      check_bit("waiting", waiting, 1'b1);
      check_state("state", state, st_prefetch);
      check_bit("vmaok", vmaok, 1'b1);
      check_bit("wrcyc", wrcyc, wr);
   endtask

   // Memory answers after a few cycles with a one-cycle memack.
   task automatic answer_memory(input logic wr, input int delay);
      for (int i = 0; i < delay; i++) begin
         @(negedge clk);
         check_stalled(wr);
      end
      @(posedge clk);
      memack <= 1'b1;
      @(negedge clk);
      check_stalled(wr);
      @(posedge clk);
      memack <= 1'b0;
      @(negedge clk);
      check_bit("memrq", memrq, 1'b0);
      check_bit("waiting", waiting, 1'b0);
      check_state("state", state, st_prefetch);
   endtask

   task automatic run_access(input mem_op_e o, input logic [`VMA_W-1:0] a);
      map_entry_t  ent;
      logic        grant;
      logic [31:0] r;
      cpu_state_e  exp_st;
      int          n;
      ent   = model_lookup(a);
      grant = model_grant(ent, o);
      take_bits(5, r);
      wait_issue_slot();
      @(posedge clk);
      req       <= 1'b1;
      op        <= o;
      vma       <= a;
      lcinc     <= r[0];
      needfetch <= r[1];
      @(posedge clk);
      req <= 1'b0;
      // Nothing goes out until the check is done.
      exp_st = st_alu;
      for (int i = 0; i < 4; i++) begin
         @(negedge clk);
         check_state("state", state, exp_st);
         check_bit("memrq", memrq, 1'b0);
         check_bit("map_fault", map_fault, 1'b0);
         exp_st = exp_st.next();
         @(posedge clk);
      end
      // Five edges after req was driven.
      @(negedge clk);
      check_state("state", state, st_prefetch);
      check_bit("vmaok", vmaok, grant);
      check_bit("memrq", memrq, grant);
      check_bit("map_fault", map_fault, ~grant);
      if (grant) begin
         n_granted++;
         check_addr("phys_addr", phys_addr, {ent[`PPAGE_W-1:0], a[`PAGE_OFF_W-1:0]});
         check_bit("wrcyc", wrcyc, o == op_write);
         check_bit("pfr", pfr, o != op_write);
         check_bit("pfw", pfw, o == op_write);
         answer_memory(o == op_write, int'(r[4:2]));
      end else begin
         n_denied++;
         n = 0;
         while (state != st_decode) begin
            check_bit("memrq", memrq, 1'b0);
            if (n == wait_limit) begin
               stop_with_error("Timed out waiting for the processor to return to decode");
            end else begin
               n++;
               @(negedge clk);
            end
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence.
   ////////////////////////////////////////////////////////////

   initial begin
      logic [31:0] r;
      int          n_wr;
      lfsr_q     = 32'hd41b_5a56;
      n_granted  = 0;
      n_denied   = 0;
      reset     <= 1'b1;
      req       <= 1'b0;
      op        <= op_none;
      vma       <= '0;
      map_wr_l1 <= 1'b0;
      map_wr_l2 <= 1'b0;
      map_wdata <= '0;
      lcinc     <= 1'b0;
      needfetch <= 1'b0;
      memack    <= 1'b0;
      repeat (5) @(posedge clk);
      reset <= 1'b0;

      // Identity on level 1 so every level-2 slot can be filled.
      for (int i = 0; i < 8; i++) begin
         map_write(1'b0, {5'(i), 11'd0}, 10'(i));
      end
      for (int i = 0; i < 64; i++) begin
         take_bits(10, r);
         map_write(1'b1, {2'b00, 6'(i), 8'd0}, r[9:0]);
      end
      for (int i = 0; i < 32; i++) begin
         take_bits(3, r);
         map_write(1'b0, {5'(i), 11'd0}, {7'd0, r[2:0]});
      end

      // The same write with write permission and then without.
      map_write(1'b1, 16'h5a3c, {2'b11, 8'h77});
      run_access(op_write, 16'h5a3c);
      map_write(1'b1, 16'h5a3c, {2'b10, 8'h77});
      run_access(op_write, 16'h5a3c);
      map_write(1'b1, 16'h5a3c, {2'b01, 8'h77});
      run_access(op_read, 16'h5a3c);
      run_access(op_ifetch, 16'h5a3c);

      // Count only the random accesses.
      n_granted = 0;
      n_denied  = 0;

      for (int k = 0; k < access_count; k++) begin
         take_bits(2, r);
         n_wr = int'(r[1:0]);
         for (int w = 0; w < n_wr; w++) begin
            take_bits(27, r);
            map_write(r[26], r[25:10], r[9:0]);
         end
         take_bits(18, r);
         run_access(op_from_bits(r[17:16]), r[15:0]);
      end

      if (n_granted == 0 || n_denied == 0) begin
         stop_with_error("Random accesses did not reach both granted and denied outcomes");
      end else begin
         $display("Test OK");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* rtl/vmem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vmem_consts.svh"

module vmem_top (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            req,
   input  vmem_pkg::mem_op_e               op,
   input  logic [`VMA_W-1:0]               vma,
   input  logic                            map_wr_l1,
   input  logic                            map_wr_l2,
   input  logic [`MAP_WDATA_W-1:0]         map_wdata,
   input  logic                            lcinc,
   input  logic                            needfetch,
   input  logic                            memack,
   output vmem_pkg::cpu_state_e            state,
   output logic                            memrq,
   output logic [`PPAGE_W+`PAGE_OFF_W-1:0] phys_addr,
   output logic                            wrcyc,
   output logic                            vmaok,
   output logic                            pfr,
   output logic                            pfw,
   output logic                            map_fault,
   output logic                            waiting
);

   import vmem_pkg::*;

   logic              memrd;
   logic              memwr;
   logic              ifetch;
   logic [`VMA_W-1:0] vma_q;
   logic              lvmo_23;
   logic              lvmo_22;
   ppage_t            ppage;

   cpu_state_seq u_seq (
      .clk     (clk),
      .reset   (reset),
      .waiting (waiting),
      .state   (state)
   );

   mem_op_latch u_latch (
      .clk       (clk),
      .reset     (reset),
      .state     (state),
      .req       (req),
      .op        (op),
      .vma       (vma),
      .memack    (memack),
      .map_fault (map_fault),
      .memrd     (memrd),
      .memwr     (memwr),
      .ifetch    (ifetch),
      .vma_q     (vma_q)
   );

   vmem_map u_map (
      .clk       (clk),
      .map_wr_l1 (map_wr_l1),
      .map_wr_l2 (map_wr_l2),
      .vma       (vma),
      .map_wdata (map_wdata),
      .vma_q     (vma_q),
      .lvmo_23   (lvmo_23),
      .lvmo_22   (lvmo_22),
      .ppage     (ppage)
   );

   vmem_ctl u_ctl (
      .clk       (clk),
      .reset     (reset),
      .state     (state),
      .memrd     (memrd),
      .memwr     (memwr),
      .ifetch    (ifetch),
      .lvmo_23   (lvmo_23),
      .lvmo_22   (lvmo_22),
      .lcinc     (lcinc),
      .needfetch (needfetch),
      .memack    (memack),
      .memrq     (memrq),
      .wrcyc     (wrcyc),
      .vmaok     (vmaok),
      .pfr       (pfr),
      .pfw       (pfw),
      .waiting   (waiting),
      .map_fault (map_fault)
   );

   // Physical page joined with the untranslated offset.
   assign phys_addr = {ppage, vma_q[`PAGE_OFF_W-1:0]};

endmodule

`default_nettype wire

/* rtl/vmem_ctl.sv */
`timescale 1ns/1ps
`default_nettype none

module vmem_ctl (
   input  logic                 clk,
   input  logic                 reset,
   input  vmem_pkg::cpu_state_e state,
   input  logic                 memrd,
   input  logic                 memwr,
   input  logic                 ifetch,
   input  logic                 lvmo_23,
   input  logic                 lvmo_22,
   input  logic                 lcinc,
   input  logic                 needfetch,
   input  logic                 memack,
   output logic                 memrq,
   output logic                 wrcyc,
   output logic                 vmaok,
   output logic                 pfr,
   output logic                 pfw,
   output logic                 waiting,
   output logic                 map_fault
);

   import vmem_pkg::*;

   logic memop;
   logic memprepare;
   logic memstart;
   logic memcheck;
   logic rdcyc;
   logic mbusy;
   logic mfinish;
   logic cyc_go;

   assign memop   = memrd | memwr | ifetch;
   assign mfinish = memack;

   ////////////////////////////////////////////////////////////
   // Prepare, start, check.
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         memprepare <= 1'b0;
      end else if (state == st_alu || state == st_write) begin
         memprepare <= memop;
      end else begin
         memprepare <= 1'b0;
      end
   end

   // Map read under way.
   always_ff @(posedge clk) begin
      if (reset) begin
         memstart <= 1'b0;
      end else if (state != st_alu) begin
         memstart <= memprepare;
      end else begin
         memstart <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         memcheck <= 1'b0;
      end else begin
         memcheck <= memstart;
      end
   end

   ////////////////////////////////////////////////////////////
   // Permission.
   ////////////////////////////////////////////////////////////

   // Reads need the access bit, writes need both.
   assign pfr = lvmo_23 & (memrd | ifetch);
   assign pfw = lvmo_23 & lvmo_22 & memwr;

   always_ff @(posedge clk) begin
      if (reset) begin
         vmaok <= 1'b0;
      end else if (memcheck) begin
         vmaok <= pfr | pfw;
      end
   end

   // Trap request for one cycle in prefetch.
   always_ff @(posedge clk) begin
      if (reset) begin
         map_fault <= 1'b0;
      end else begin
         map_fault <= (state == st_fetch) & memstart & memcheck & ~(pfr | pfw);
      end
   end

   ////////////////////////////////////////////////////////////
   // Bus cycle.
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         rdcyc <= 1'b0;
         wrcyc <= 1'b0;
      end else if (state == st_fetch && memstart && memcheck) begin
         rdcyc <= ~memwr;
         wrcyc <= memwr;
      end else if ((~memrq && ~memprepare && ~memstart) || mfinish) begin
         rdcyc <= 1'b0;
         wrcyc <= 1'b0;
      end
   end

   // Check cycle with the cycle type already chosen.
   assign cyc_go = memcheck & (rdcyc | wrcyc);

   assign memrq = mbusy | (cyc_go & (pfr | pfw));

   always_ff @(posedge clk) begin
      if (reset) begin
         mbusy <= 1'b0;
      end else if (mfinish) begin
         mbusy <= 1'b0;
      end else if (cyc_go & (pfr | pfw)) begin
         mbusy <= 1'b1;
      end
   end

   // Hold the sequencer while the bus cycle is open.
   assign waiting = memrq | (lcinc & needfetch & mbusy);

   // A request goes out only on a permitted check.
   a_rq_vmaok : assert property (@(posedge clk) disable iff (reset)
      $rose(memrq) |=> vmaok);

endmodule

`default_nettype wire

/* rtl/vmem_map.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vmem_consts.svh"

module vmem_map (
   input  logic                    clk,
   input  logic                    map_wr_l1,
   input  logic                    map_wr_l2,
   input  logic [`VMA_W-1:0]       vma,
   input  logic [`MAP_WDATA_W-1:0] map_wdata,
   input  logic [`VMA_W-1:0]       vma_q,
   output logic                    lvmo_23,
   output logic                    lvmo_22,
   output logic [`PPAGE_W-1:0]     ppage
);

   import vmem_pkg::*;

   localparam int l1_idx_w = `L1_IDX_HI - `L1_IDX_LO + 1;
   localparam int l2_idx_w = `L2_BLK_W + `L2_IDX_HI - `L2_IDX_LO + 1;

   ////////////////////////////////////////////////////////////
   // Map storage.
   ////////////////////////////////////////////////////////////

   l2_blk_t    l1_mem [2**l1_idx_w];
   map_entry_t l2_mem [2**l2_idx_w];

   logic [l1_idx_w-1:0] wr_l1_idx;
   logic [l1_idx_w-1:0] rd_l1_idx;
   logic [l2_idx_w-1:0] wr_l2_idx;
   logic [l2_idx_w-1:0] rd_l2_idx;
   map_entry_t          entry_q;

   assign wr_l1_idx = vma[`L1_IDX_HI:`L1_IDX_LO];
   assign rd_l1_idx = vma_q[`L1_IDX_HI:`L1_IDX_LO];

   // Level-2 slot is the block from level 1 joined with the middle bits.
   assign wr_l2_idx = {l1_mem[wr_l1_idx], vma[`L2_IDX_HI:`L2_IDX_LO]};
   assign rd_l2_idx = {l1_mem[rd_l1_idx], vma_q[`L2_IDX_HI:`L2_IDX_LO]};

   always_ff @(posedge clk) begin
      if (map_wr_l1) begin
         l1_mem[wr_l1_idx] <= map_wdata[`L2_BLK_W-1:0];
      end
      if (map_wr_l2) begin
         l2_mem[wr_l2_idx] <= map_wdata;
      end
   end

   // Registered lookup.
   always_ff @(posedge clk) begin
      entry_q <= l2_mem[rd_l2_idx];
   end

   assign lvmo_23 = entry_q[`MAP_WDATA_W-1];
   assign lvmo_22 = entry_q[`MAP_WDATA_W-2];
   assign ppage   = entry_q[`PPAGE_W-1:0];

   // One map level written at a time.
   a_one_write : assert property (@(posedge clk)
      !(map_wr_l1 && map_wr_l2));

endmodule

`default_nettype wire

/* rtl/mem_op_latch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vmem_consts.svh"

module mem_op_latch (
   input  logic                 clk,
   input  logic                 reset,
   input  vmem_pkg::cpu_state_e state,
   input  logic                 req,
   input  vmem_pkg::mem_op_e    op,
   input  logic [`VMA_W-1:0]    vma,
   input  logic                 memack,
   input  logic                 map_fault,
   output logic                 memrd,
   output logic                 memwr,
   output logic                 ifetch,
   output logic [`VMA_W-1:0]    vma_q
);

   import vmem_pkg::*;

   mem_op_e op_q;
   logic    accept;

   // Requests are only taken at the start of a cycle.
   assign accept = req && (state == st_decode);

   always_ff @(posedge clk) begin
      if (reset) begin
         op_q <= op_none;
      end else if (memack || map_fault) begin
         // Done or trapped.
         op_q <= op_none;
      end else if (accept) begin
         op_q <= op;
      end
   end

   // Address payload.
   always_ff @(posedge clk) begin
      if (accept) begin
         vma_q <= vma;
      end
   end

   ////////////////////////////////////////////////////////////
   // Opcode decode.
   ////////////////////////////////////////////////////////////

   assign memrd  = (op_q == op_read);
   assign memwr  = (op_q == op_write);
   assign ifetch = (op_q == op_ifetch);

   // No new request while one is still held.
   a_no_overlap : assert property (@(posedge clk) disable iff (reset)
      req |-> (op_q == op_none));

endmodule

`default_nettype wire

/* rtl/cpu_state_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_state_seq (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 waiting,
   output vmem_pkg::cpu_state_e state
);

   import vmem_pkg::*;

   cpu_state_e state_nxt;

   // Step around the ring, hold while memory is busy.
   always_comb begin
      state_nxt = state;
      if (!waiting) begin
         case (state)
            st_decode:   state_nxt = st_alu;
            st_alu:      state_nxt = st_write;
            st_write:    state_nxt = st_mmu;
            st_mmu:      state_nxt = st_fetch;
            st_fetch:    state_nxt = st_prefetch;
            st_prefetch: state_nxt = st_decode;
            default:     state_nxt = st_decode;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_decode;
      end else begin
         state <= state_nxt;
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks.
   ////////////////////////////////////////////////////////////

   // Only the six phases ever appear.
   a_state_legal : assert property (@(posedge clk) disable iff (reset)
      state inside {st_decode, st_alu, st_write, st_mmu, st_fetch, st_prefetch});

endmodule

`default_nettype wire

/* rtl/vmem_pkg.sv */
`default_nettype none

`include "vmem_consts.svh"

package vmem_pkg;

   ////////////////////////////////////////////////////////////
   // Processor cycle phases, in ring order.
   ////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      st_decode   = 3'd0,
      st_alu      = 3'd1,
      st_write    = 3'd2,
      st_mmu      = 3'd3,
      st_fetch    = 3'd4,
      st_prefetch = 3'd5
   } cpu_state_e;

   // Memory request opcodes.
   typedef enum logic [1:0] {
      op_none   = 2'd0,
      op_read   = 2'd1,
      op_write  = 2'd2,
      op_ifetch = 2'd3
   } mem_op_e;

   ////////////////////////////////////////////////////////////
   // Map entries.
   ////////////////////////////////////////////////////////////

   // Level-1 entry holds a level-2 block number.
   typedef logic [`L2_BLK_W-1:0] l2_blk_t;

   // Level-2 entry holds the access bit, the write bit and the physical page.
   typedef logic [`MAP_WDATA_W-1:0] map_entry_t;

   typedef logic [`PPAGE_W-1:0] ppage_t;

endpackage

`default_nettype wire

/* rtl/vmem_consts.svh */
`ifndef VMEM_CONSTS_SVH
`define VMEM_CONSTS_SVH

// Virtual address and its split into map index fields.
`define VMA_W        16
`define L1_IDX_HI    15
`define L1_IDX_LO    11
`define L2_IDX_HI    10
`define L2_IDX_LO    8
`define PAGE_OFF_W   8

// Map contents.
`define L2_BLK_W     3
`define PPAGE_W      8
`define MAP_WDATA_W  10

`endif
